// ==== common/soc_pkg.sv ====
// Shared bus types, memory map bits and UART states; the I/O page offset covers address bits 12..2 only
`default_nettype none

package soc_pkg;

   // One bus word, used for both data and addresses
   typedef logic [31:0] word_t;

   // One write enable per byte lane
   typedef logic [3:0] byte_mask_t;

   // Word offset inside the I/O page
   typedef logic [10:0] io_offset_t;

   // Address bit that selects the I/O page instead of RAM
   localparam int io_page_bit = 22;

   // One-hot device selects within the I/O word offset
   localparam int hw_ram_bit  = 0;
   localparam int hw_freq_bit = 1;
   localparam int leds_bit    = 2;
   localparam int uart_bit    = 3;
   localparam int buttons_bit = 4;

   // Transmitter frame phases
   typedef enum logic [1:0] {
      st_idle,
      st_start,
      st_data,
      st_stop
   } uart_state_t;

endpackage

`default_nettype wire

// ==== common/io_bus_if.sv ====
// Decoded I/O page bus; strobes are already qualified by the page bit, rdata is valid a cycle after rstrb
`default_nettype none

interface io_bus_if import soc_pkg::*; ();

   // Strobes for the I/O page only
   logic       rstrb;
   logic       wstrb;
   // Word offset with one-hot device bits
   io_offset_t offset;
   word_t      wdata;
   // Latched read data and merged busy from the page
   word_t      rdata;
   logic       wbusy;

   modport decoder (
      output rstrb, wstrb, offset, wdata,
      input  rdata, wbusy
   );

   modport page (
      input  rstrb, wstrb, offset, wdata,
      output rdata, wbusy
   );

endinterface

`default_nettype wire

// ==== source/reset_stretch.sv ====
// Internal reset stays low for reset_delay clock edges after RESET rises; reset_delay must be at least 1
`default_nettype none

module reset_stretch #(
   parameter int reset_delay = 16
) (
   input  logic clk,
   input  logic RESET,
   output logic core_reset_n
);

   localparam int cnt_w = $clog2(reset_delay + 1);

   logic [cnt_w-1:0] cnt;
   logic [cnt_w-1:0] cnt_next;

   // Saturates at the terminal count
   assign cnt_next = (cnt == cnt_w'(reset_delay)) ? cnt : cnt + 1'b1;

   always_ff @(posedge clk or negedge RESET) begin
      if (!RESET) begin
         cnt          <= '0;
         core_reset_n <= 1'b0;
      end else begin
         cnt          <= cnt_next;
         // Release on the same edge that reaches the terminal count
         core_reset_n <= (cnt_next == cnt_w'(reset_delay));
      end
   end

   // Release only after RESET has been high for the whole stretch
   a_no_early_release: assert property (
      @(posedge clk) disable iff (!RESET)
      $rose(core_reset_n) |-> $past(RESET, reset_delay)
   );

endmodule

`default_nettype wire

// ==== source/soc_ram.sv ====
// Word RAM with byte-lane writes and one-cycle registered read; contents start undefined
`default_nettype none

module soc_ram import soc_pkg::*; #(
   parameter int ram_addr_bits = 10
) (
   input  logic                     clk,
   input  logic                     we,
   input  logic [ram_addr_bits-1:0] word_addr,
   input  byte_mask_t               wmask,
   input  word_t                    wdata,
   output word_t                    rdata
);

   localparam int depth = 1 << ram_addr_bits;

   // Storage array
   word_t mem [0:depth-1];

   // Lane writes and the read register share one port
   always_ff @(posedge clk) begin
      if (we) begin
         for (int lane = 0; lane < 4; lane++) begin
            // Only lanes enabled in the mask change
            if (wmask[lane]) begin
               mem[word_addr][lane*8 +: 8] <= wdata[lane*8 +: 8];
            end
         end
      end
      // Read every cycle
      // a write to the same word shows up one read later
      rdata <= mem[word_addr];
   end

endmodule

`default_nettype wire

// ==== source/bus_decode.sv ====
// Host bus splitter; the master must never raise rstrb and a write mask together, nor write while wbusy
`default_nettype none

module bus_decode import soc_pkg::*; (
   input  logic       clk,
   input  logic       RESET,
   input  word_t      addr,
   input  byte_mask_t wmask,
   input  word_t      wdata,
   input  logic       rstrb,
   output word_t      rdata,
   output logic       wbusy,
   output logic       ram_we,
   input  word_t      ram_rdata,
   io_bus_if.decoder  io
);

   logic is_io;
   logic wstrb;
   // Target of the most recent read
   logic rd_is_io;

   assign is_io = addr[io_page_bit];
   assign wstrb = |wmask;

   // RAM sees writes below the I/O page
   assign ram_we = wstrb && !is_io;

   // I/O page strobes and payload
   assign io.rstrb  = rstrb && is_io;
   assign io.wstrb  = wstrb && is_io;
   assign io.offset = addr[2 +: $bits(io_offset_t)];
   assign io.wdata  = wdata;

   // Remember where the read went so the returned word comes from the right register
   always_ff @(posedge clk or negedge RESET) begin
      if (!RESET) begin
         rd_is_io <= 1'b0;
      end else if (rstrb) begin
         rd_is_io <= is_io;
      end
   end

   assign rdata = rd_is_io ? io.rdata : ram_rdata;

   // Only the UART blocks
   assign wbusy = io.wbusy;

   // Reads and writes from the master never overlap
   a_no_rw_overlap: assert property (
      @(posedge clk) disable iff (!RESET)
      !(rstrb && wstrb)
   );

endmodule

`default_nettype wire

// ==== io/uart_tx.sv ====
// 8N1 transmitter; clk_freq_hz should be a multiple of baud_rate, start is ignored unless idle
`default_nettype none

module uart_tx import soc_pkg::*; #(
   parameter int clk_freq_hz = 50_000_000,
   parameter int baud_rate   = 115_200
) (
   input  logic       clk,
   input  logic       core_reset_n,
   input  logic       start,
   input  logic [7:0] data,
   output logic       busy,
   output logic       tx
);

   // Clocks per bit
   localparam int div   = clk_freq_hz / baud_rate;
   localparam int cnt_w = (div > 1) ? $clog2(div) : 1;

   uart_state_t      state;
   logic [cnt_w-1:0] baud_cnt;
   logic [2:0]       bit_cnt;
   logic [7:0]       shift;
   logic             bit_end;

   assign bit_end = (baud_cnt == cnt_w'(div - 1));
   assign busy    = (state != st_idle);

   always_ff @(posedge clk or negedge core_reset_n) begin
      if (!core_reset_n) begin
         state    <= st_idle;
         baud_cnt <= '0;
         bit_cnt  <= '0;
         tx       <= 1'b1;
      end else begin
         // Bit timer runs only inside a frame
         if (state == st_idle || bit_end) begin
            baud_cnt <= '0;
         end else begin
            baud_cnt <= baud_cnt + 1'b1;
         end
         case (state)
            st_idle: begin
               if (start) begin
                  state <= st_start;
                  tx    <= 1'b0;
               end
            end
            st_start: begin
               if (bit_end) begin
                  state   <= st_data;
                  bit_cnt <= '0;
                  tx      <= shift[0];
               end
            end
            st_data: begin
               if (bit_end) begin
                  // LSB first then the stop bit
                  if (bit_cnt == 3'd7) begin
                     state <= st_stop;
                     tx    <= 1'b1;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                     tx      <= shift[1];
                  end
               end
            end
            default: begin
               if (bit_end) begin
                  state <= st_idle;
               end
            end
         endcase
      end
   end

   // Byte shifter
   always_ff @(posedge clk) begin
      if (state == st_idle && start) begin
         shift <= data;
      end else if (state == st_data && bit_end) begin
         shift <= {1'b0, shift[7:1]};
      end
   end

   // Line rests high between frames
   a_idle_mark: assert property (
      @(posedge clk) disable iff (!core_reset_n)
      (state == st_idle) |-> tx
   );

endmodule

`default_nettype wire

// ==== io/io_page.sv ====
// I/O page with one-hot device decode; several set bits return the OR, rdata is latched on rstrb
`default_nettype none

module io_page import soc_pkg::*; #(
   parameter int ram_addr_bits = 10,
   parameter int clk_freq_hz   = 50_000_000,
   parameter int baud_rate     = 115_200
) (
   input  logic       clk,
   input  logic       core_reset_n,
   io_bus_if.page     io,
   output logic [3:0] leds,
   input  logic [5:0] buttons,
   output logic       tx
);

   // Hardware configuration words
   localparam word_t hw_ram_size = word_t'(4) << ram_addr_bits;
   localparam word_t hw_freq     = word_t'(clk_freq_hz);

   logic       uart_start;
   logic       uart_busy;
   logic [5:0] btn_meta;
   logic [5:0] btn_sync;
   word_t      rd_val;
   word_t      rdata_q;

   // LED register
   always_ff @(posedge clk or negedge core_reset_n) begin
      if (!core_reset_n) begin
         leds <= '0;
      end else if (io.wstrb && io.offset[leds_bit]) begin
         leds <= io.wdata[3:0];
      end
   end

   // Two-flop synchroniser for the buttons
   always_ff @(posedge clk) begin
      btn_meta <= buttons;
      btn_sync <= btn_meta;
   end

   // UART takes the low byte
   // writes during a frame are dropped inside the transmitter
   assign uart_start = io.wstrb && io.offset[uart_bit];

   uart_tx #(
      .clk_freq_hz (clk_freq_hz),
      .baud_rate   (baud_rate)
   ) u_uart_tx (
      .clk          (clk),
      .core_reset_n (core_reset_n),
      .start        (uart_start),
      .data         (io.wdata[7:0]),
      .busy         (uart_busy),
      .tx           (tx)
   );

   // OR of every selected device
   always_comb begin
      rd_val = '0;
      if (io.offset[hw_ram_bit]) begin
         rd_val |= hw_ram_size;
      end
      if (io.offset[hw_freq_bit]) begin
         rd_val |= hw_freq;
      end
      if (io.offset[leds_bit]) begin
         rd_val |= word_t'(leds);
      end
      // Busy flag sits in bit 0
      if (io.offset[uart_bit]) begin
         rd_val |= word_t'(uart_busy);
      end
      if (io.offset[buttons_bit]) begin
         rd_val |= word_t'(btn_sync);
      end
   end

   // Read data latch
   always_ff @(posedge clk or negedge core_reset_n) begin
      if (!core_reset_n) begin
         rdata_q <= '0;
      end else if (io.rstrb) begin
         rdata_q <= rd_val;
      end
   end

   assign io.rdata = rdata_q;
   assign io.wbusy = uart_busy;

endmodule

`default_nettype wire

// ==== source/soc_fabric.sv ====
// Memory and I/O fabric top; ram_addr_bits may not exceed 20 and the master runs from core_reset_n
`default_nettype none

module soc_fabric import soc_pkg::*; #(
   parameter int ram_addr_bits = 10,
   parameter int clk_freq_hz   = 50_000_000,
   parameter int baud_rate     = 115_200,
   parameter int reset_delay   = 16
) (
   input  logic       clk,
   input  logic       RESET,
   output logic       core_reset_n,
   input  word_t      addr,
   input  word_t      wdata,
   input  byte_mask_t wmask,
   input  logic       rstrb,
   output word_t      rdata,
   output logic       rbusy,
   output logic       wbusy,
   output logic [3:0] leds,
   input  logic [5:0] buttons,
   output logic       tx
);

   logic  ram_we;
   word_t ram_rdata;

   io_bus_if io_bus ();

   // No device blocks on read
   assign rbusy = 1'b0;

   reset_stretch #(
      .reset_delay (reset_delay)
   ) u_reset_stretch (
      .clk          (clk),
      .RESET        (RESET),
      .core_reset_n (core_reset_n)
   );

   // Decoder held in reset together with the master
   bus_decode u_bus_decode (
      .clk       (clk),
      .RESET     (core_reset_n),
      .addr      (addr),
      .wmask     (wmask),
      .wdata     (wdata),
      .rstrb     (rstrb),
      .rdata     (rdata),
      .wbusy     (wbusy),
      .ram_we    (ram_we),
      .ram_rdata (ram_rdata),
      .io        (io_bus.decoder)
   );

   // Word address starts at bit 2
   soc_ram #(
      .ram_addr_bits (ram_addr_bits)
   ) u_soc_ram (
      .clk       (clk),
      .we        (ram_we),
      .word_addr (addr[ram_addr_bits+1:2]),
      .wmask     (wmask),
      .wdata     (wdata),
      .rdata     (ram_rdata)
   );

   io_page #(
      .ram_addr_bits (ram_addr_bits),
      .clk_freq_hz   (clk_freq_hz),
      .baud_rate     (baud_rate)
   ) u_io_page (
      .clk          (clk),
      .core_reset_n (core_reset_n),
      .io           (io_bus.page),
      .leds         (leds),
      .buttons      (buttons),
      .tx           (tx)
   );

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
// Testbench clock of 4 ns period; RESET is held low for reset_cycles rising edges and then released
`default_nettype none

module clock_gen #(
   parameter int reset_cycles = 10
) (
   output logic clk,
   output logic RESET
);

   timeunit 1ns;
   timeprecision 100ps;

   // Free-running clock
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Release on a rising edge, like any other driven input
   initial begin
      RESET = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      RESET <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== bench/tb_soc.sv ====
// Self-checking bench for soc_fabric; assumes a 1024-word RAM, 8 clocks per UART bit, 16-cycle stretch
`default_nettype none

module tb_soc import soc_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int bit_clocks   = 8;
   localparam int frame_clocks = 10 * bit_clocks;
   localparam int reset_wait   = 16;
   localparam int wait_limit   = 200;

   // I/O page addresses, one-hot selects in the word offset
   localparam word_t io_base     = word_t'(1) << io_page_bit;
   localparam word_t hw_ram_addr = io_base | (word_t'(1) << (2 + hw_ram_bit));
   localparam word_t hw_frq_addr = io_base | (word_t'(1) << (2 + hw_freq_bit));
   localparam word_t led_addr    = io_base | (word_t'(1) << (2 + leds_bit));
   localparam word_t uart_addr   = io_base | (word_t'(1) << (2 + uart_bit));
   localparam word_t btn_addr    = io_base | (word_t'(1) << (2 + buttons_bit));

   logic       clk;
   logic       RESET;
   logic       core_reset_n;
   word_t      addr;
   word_t      wdata;
   byte_mask_t wmask;
   logic       rstrb;
   word_t      rdata;
   logic       rbusy;
   logic       wbusy;
   logic [3:0] leds;
   logic [5:0] buttons;
   logic       tx;

   // Reference models
   word_t       ram_model [0:1023];
   logic [3:0]  exp_leds   = 4'h0;
   word_t       exp_rdata  = '0;
   logic        frame_kick = 1'b0;
   logic [7:0]  frame_byte = 8'h00;
   int          frame_cyc  = 0;
   int          rel_cnt    = 0;
   logic        armed      = 1'b0;
   logic [9:0]  used_addr [$];

   clock_gen #(.reset_cycles(10)) u_clock_gen (.clk(clk), .RESET(RESET));

   soc_fabric #(
      .ram_addr_bits (10),
      .clk_freq_hz   (250_000_000),
      .baud_rate     (31_250_000),
      .reset_delay   (reset_wait)
   ) UUT (
      .clk          (clk),
      .RESET        (RESET),
      .core_reset_n (core_reset_n),
      .addr         (addr),
      .wdata        (wdata),
      .wmask        (wmask),
      .rstrb        (rstrb),
      .rdata        (rdata),
      .rbusy        (rbusy),
      .wbusy        (wbusy),
      .leds         (leds),
      .buttons      (buttons),
      .tx           (tx)
   );

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input word_t got, input word_t want);
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, want);
      abort_run();
   endtask

   // Line level expected at mid-bit, idle line is high
   function automatic logic expected_line(input int cyc, input logic [7:0] b);
      int         idx;
      logic [2:0] sel;
      if (cyc == 0) begin
         return 1'b1;
      end
      idx = (cyc - 1) / bit_clocks;
      sel = 3'(idx - 1);
      if (idx == 0) begin
         return 1'b0;
      end
      if (idx <= 8) begin
         return b[sel];
      end
      return 1'b1;
   endfunction

   // Lane merge of a masked write
   function automatic word_t merge_lanes(input word_t old, input word_t d, input byte_mask_t m);
      word_t bits;
      bits = {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
      return (old & ~bits) | (d & bits);
   endfunction

   function automatic word_t ram_addr(input logic [9:0] wa);
      return {20'b0, wa, 2'b00};
   endfunction

   // Edges seen since the external reset was released
   always @(posedge clk or negedge RESET) begin
      if (!RESET) begin
         rel_cnt <= 0;
      end else if (rel_cnt < 1000) begin
         rel_cnt <= rel_cnt + 1;
      end
   end

   always @(posedge clk) begin
      armed <= 1'b1;
   end

   // Frame cycle counter, 1 in the first busy cycle up to 80 in the last
   always @(posedge clk) begin
      if (frame_kick) begin
         frame_cyc <= 1;
      end else if (frame_cyc != 0) begin
         frame_cyc <= (frame_cyc == frame_clocks) ? 0 : frame_cyc + 1;
      end
   end

   a_release_time: assert property (@(posedge clk) disable iff (!armed)
      core_reset_n == (rel_cnt >= reset_wait))
      else report_mismatch("core_reset_n", word_t'($sampled(core_reset_n)),
                           word_t'($sampled(rel_cnt) >= reset_wait));

   a_reset_pins: assert property (@(posedge clk) disable iff (!armed)
      !core_reset_n |-> (!wbusy && tx && leds == 4'h0))
      else report_mismatch("wbusy,tx,leds", {23'b0, $sampled(wbusy), 3'b0, $sampled(tx),
                           $sampled(leds)}, 32'h0000_0010);

   a_read_data: assert property (@(posedge clk) disable iff (!armed)
      rstrb |=> (rdata == exp_rdata))
      else report_mismatch("rdata", $sampled(rdata), $sampled(exp_rdata));

   a_leds: assert property (@(posedge clk) disable iff (!armed) leds == exp_leds)
      else report_mismatch("leds", word_t'($sampled(leds)), word_t'($sampled(exp_leds)));

   a_rbusy: assert property (@(posedge clk) disable iff (!armed) !rbusy)
      else report_mismatch("rbusy", word_t'($sampled(rbusy)), 32'h0);

   // Busy exactly for the 80 frame cycles
   a_busy_window: assert property (@(posedge clk) disable iff (!armed)
      wbusy == (frame_cyc != 0))
      else report_mismatch("wbusy", word_t'($sampled(wbusy)), word_t'($sampled(frame_cyc) != 0));

   a_tx_line: assert property (@(posedge clk) disable iff (!armed)
      (frame_cyc == 0 || frame_cyc % bit_clocks == 4) |-> tx == expected_line(frame_cyc, frame_byte))
      else report_mismatch("tx", word_t'($sampled(tx)),
                           word_t'(expected_line($sampled(frame_cyc), $sampled(frame_byte))));

   task automatic wait_core_release();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!core_reset_n) begin
         if (cycles >= wait_limit) begin
            $display("Timeout: core reset was never released");
            abort_run();
         end else begin
            cycles++;
            @(negedge clk);
         end
      end
   endtask

   task automatic wait_write_ready();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (wbusy) begin
         if (cycles >= wait_limit) begin
            $display("Timeout: wbusy stayed high");
            abort_run();
         end else begin
            cycles++;
            @(negedge clk);
         end
      end
   endtask

   // Masked write, models follow at the edge that ends the write cycle
   task automatic write_word(input word_t a, input word_t d, input byte_mask_t m);
      wait_write_ready();
      @(posedge clk);
      addr  <= a;
      wdata <= d;
      wmask <= m;
      if (a[io_page_bit] && a[2 + uart_bit]) begin
         frame_kick <= 1'b1;
         frame_byte <= d[7:0];
      end
      @(posedge clk);
      wmask      <= '0;
      frame_kick <= 1'b0;
      if (!a[io_page_bit]) begin
         ram_model[a[11:2]] = merge_lanes(ram_model[a[11:2]], d, m);
      end else if (a[2 + leds_bit]) begin
         exp_leds <= d[3:0];
      end
   endtask

   // Address stays put in the cycle after the strobe
   task automatic read_word(input word_t a, input word_t want);
      @(posedge clk);
      addr      <= a;
      rstrb     <= 1'b1;
      exp_rdata <= want;
      @(posedge clk);
      rstrb <= 1'b0;
   endtask

   initial begin
      logic [9:0]  wa;
      logic [7:0]  tx_byte;
      logic [5:0]  btn_val;
      int unsigned seed_draw;
      addr      = '0;
      wdata     = '0;
      wmask     = '0;
      rstrb     = 1'b0;
      buttons   = '0;
      seed_draw = $urandom(53708);
      wait_core_release();

      // RAM with full fills then random lane writes
      for (int i = 0; i < 16; i++) begin
         wa = 10'($urandom_range(1023, 0));
         used_addr.push_back(wa);
         write_word(ram_addr(wa), $urandom(), 4'hF);
      end
      for (int i = 0; i < 32; i++) begin
         wa = used_addr[$urandom_range(15, 0)];
         write_word(ram_addr(wa), $urandom(), 4'($urandom_range(15, 1)));
         read_word(ram_addr(wa), ram_model[wa]);
      end
      foreach (used_addr[i]) begin
         read_word(ram_addr(used_addr[i]), ram_model[used_addr[i]]);
      end

      // LED write shares its low address bits with RAM word 4
      write_word(32'h0000_0010, $urandom(), 4'hF);
      write_word(led_addr, {28'b0, 4'($urandom_range(15, 1))}, 4'hF);
      read_word(32'h0000_0010, ram_model[10'd4]);
      read_word(led_addr, {28'b0, exp_leds});

      // Hardware configuration
      read_word(hw_ram_addr, 32'd4096);
      read_word(hw_frq_addr, 32'd250_000_000);
      read_word(hw_ram_addr | hw_frq_addr, 32'd4096 | 32'd250_000_000);

      repeat (3) begin
         btn_val = 6'($urandom_range(63, 0));
         @(posedge clk);
         buttons <= btn_val;
         repeat (4) @(posedge clk);
         read_word(btn_addr, {26'b0, btn_val});
      end

      // UART frames with a status read inside and after each one
      repeat (2) begin
         tx_byte = 8'($urandom_range(255, 0));
         write_word(uart_addr, {24'b0, tx_byte}, 4'b0001);
         read_word(uart_addr, 32'h1);
         wait_write_ready();
         read_word(uart_addr, 32'h0);
      end

      repeat (4) @(posedge clk);
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
common/soc_pkg.sv
common/io_bus_if.sv
source/reset_stretch.sv
source/soc_ram.sv
source/bus_decode.sv
io/uart_tx.sv
io/io_page.sv
source/soc_fabric.sv
bench/clock_gen.sv
bench/tb_soc.sv

// ==== Makefile ====
TOP := tb_soc

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f project.f

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
